// ==== design/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // ********************************************************
    // major opcodes
    // ********************************************************
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // machine csrs kept by the core
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

    // ********************************************************
    // control enums
    // ********************************************************
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
    } alu_op_e;

    typedef enum logic {A_REG, A_PC} alu_a_e;

    typedef enum logic [1:0] {B_REG, B_IMM, B_FOUR} alu_b_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JAL, BR_JALR, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } branch_e;

    // same coding as funct3 of loads and stores
    typedef enum logic [2:0] {
        MEM_B  = 3'b000,
        MEM_H  = 3'b001,
        MEM_W  = 3'b010,
        MEM_D  = 3'b011,
        MEM_BU = 3'b100,
        MEM_HU = 3'b101,
        MEM_WU = 3'b110
    } mem_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_CSR} wb_sel_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [core_pkg::XLEN-1:0] next_pc,
    input  logic                     trap_taken,
    input  logic [core_pkg::XLEN-1:0] trap_pc,
    input  logic                     halt,
    output logic [core_pkg::XLEN-1:0] pc
);
    import core_pkg::*;

    // trap redirect wins over halt
    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= RESET_PC;
        end else if (trap_taken) begin
            pc <= trap_pc;
        end else if (!halt) begin
            pc <= next_pc;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) rst |=> (pc[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic [31:0]               instr,
    output logic [4:0]                rs1,
    output logic [4:0]                rs2,
    output logic [4:0]                rd,
    output logic [core_pkg::XLEN-1:0] imm,
    output core_pkg::alu_op_e         alu_op,
    output core_pkg::alu_a_e          alu_a,
    output core_pkg::alu_b_e          alu_b,
    output core_pkg::branch_e         branch,
    output core_pkg::mem_op_e         mem_op,
    output logic                      mem_rd,
    output logic                      mem_wr,
    output logic                      reg_wen,
    output core_pkg::wb_sel_e         wb_sel,
    output core_pkg::csr_op_e         csr_op,
    output logic                      csr_use_imm,
    output logic [11:0]               csr_addr,
    output logic                      is_ecall,
    output logic                      is_mret,
    output logic                      is_ebreak,
    output logic                      illegal
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign csr_addr = instr[31:20];

    // shared by register and immediate arithmetic
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    always_comb begin
        imm         = {{52{instr[31]}}, instr[31:20]};
        alu_op      = ALU_ADD;
        alu_a       = A_REG;
        alu_b       = B_IMM;
        branch      = BR_NONE;
        mem_op      = mem_op_e'(funct3);
        mem_rd      = 1'b0;
        mem_wr      = 1'b0;
        reg_wen     = 1'b0;
        wb_sel      = WB_ALU;
        csr_op      = CSR_NONE;
        csr_use_imm = funct3[2];
        is_ecall    = 1'b0;
        is_mret     = 1'b0;
        is_ebreak   = 1'b0;
        illegal     = 1'b0;

        case (opcode)
            OP_LUI: begin
                imm     = {{32{instr[31]}}, instr[31:12], 12'b0};
                alu_op  = ALU_COPY_B;
                reg_wen = 1'b1;
            end
            OP_AUIPC: begin
                imm     = {{32{instr[31]}}, instr[31:12], 12'b0};
                alu_a   = A_PC;
                reg_wen = 1'b1;
            end
            OP_JAL: begin
                imm     = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
                branch  = BR_JAL;
                alu_a   = A_PC;
                alu_b   = B_FOUR;
                reg_wen = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    branch  = BR_JALR;
                    alu_a   = A_PC;
                    alu_b   = B_FOUR;
                    reg_wen = 1'b1;
                end else begin
                    illegal = 1'b1;
                end
            end
            OP_BRANCH: begin
                imm = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
                case (funct3)
                    3'b000:  branch = BR_EQ;
                    3'b001:  branch = BR_NE;
                    3'b100:  branch = BR_LT;
                    3'b101:  branch = BR_GE;
                    3'b110:  branch = BR_LTU;
                    3'b111:  branch = BR_GEU;
                    default: illegal = 1'b1;
                endcase
            end
            OP_LOAD: begin
                illegal = (funct3 == 3'b111);
                mem_rd  = 1'b1;
                reg_wen = 1'b1;
                wb_sel  = WB_LOAD;
            end
            OP_STORE: begin
                imm     = {{52{instr[31]}}, instr[31:25], instr[11:7]};
                illegal = funct3[2];
                mem_wr  = 1'b1;
            end
            OP_IMM: begin
                // shamt is 6 bits on rv64, funct6 sits above it
                if (funct3 == 3'b001) begin
                    illegal = (instr[31:26] != 6'b000000);
                end else if (funct3 == 3'b101) begin
                    illegal = (instr[31:26] != 6'b000000) && (instr[31:26] != 6'b010000);
                end
                alu_op  = arith_op(funct3, (funct3 == 3'b101) && instr[30]);
                reg_wen = 1'b1;
            end
            OP_REG: begin
                illegal = !((funct7 == 7'b0000000) ||
                            ((funct7 == 7'b0100000) &&
                             ((funct3 == 3'b000) || (funct3 == 3'b101))));
                alu_op  = arith_op(funct3, instr[30]);
                alu_b   = B_REG;
                reg_wen = 1'b1;
            end
            OP_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    case (instr)
                        32'h0000_0073: is_ecall  = 1'b1;
                        32'h0010_0073: is_ebreak = 1'b1;
                        32'h3020_0073: is_mret   = 1'b1;
                        default:       illegal   = 1'b1;
                    endcase
                end else if (funct3 == 3'b100) begin
                    illegal = 1'b1;
                end else begin
                    reg_wen = 1'b1;
                    wb_sel  = WB_CSR;
                    // set and clear with a zero source only read
                    case (funct3[1:0])
                        2'b01:   csr_op = CSR_WRITE;
                        2'b10:   csr_op = (rs1 == 5'd0) ? CSR_NONE : CSR_SET;
                        default: csr_op = (rs1 == 5'd0) ? CSR_NONE : CSR_CLEAR;
                    endcase
                end
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                      clk,
    input  logic                      wen,
    input  logic [4:0]                waddr,
    input  logic [core_pkg::XLEN-1:0] wdata,
    input  logic [4:0]                raddr1,
    input  logic [4:0]                raddr2,
    output logic [core_pkg::XLEN-1:0] rdata1,
    output logic [core_pkg::XLEN-1:0] rdata2
);
    import core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (wen && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [core_pkg::XLEN-1:0] rs1_data,
    input  logic [core_pkg::XLEN-1:0] rs2_data,
    input  logic [core_pkg::XLEN-1:0] imm,
    input  core_pkg::alu_op_e         alu_op,
    input  core_pkg::alu_a_e          alu_a,
    input  core_pkg::alu_b_e          alu_b,
    input  core_pkg::branch_e         branch,
    output logic [core_pkg::XLEN-1:0] alu_result,
    output logic [core_pkg::XLEN-1:0] next_pc
);
    import core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic            taken;

    assign op_a  = (alu_a == A_PC) ? pc : rs1_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (alu_b)
            B_REG:   op_b = rs2_data;
            B_IMM:   op_b = imm;
            default: op_b = 64'd4;
        endcase
    end

    // ********************************************************
    // alu
    // ********************************************************
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << shamt;
            ALU_SLT:  alu_result = {63'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {63'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> shamt;
            ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_b;
        endcase
    end

    // compare always on the register operands
    always_comb begin
        case (branch)
            BR_JAL:  taken = 1'b1;
            BR_EQ:   taken = (rs1_data == rs2_data);
            BR_NE:   taken = (rs1_data != rs2_data);
            BR_LT:   taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  taken = (rs1_data < rs2_data);
            BR_GEU:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (branch == BR_JALR) begin
            next_pc = (rs1_data + imm) & ~64'd1;
        end else if (taken) begin
            next_pc = pc + imm;
        end else begin
            next_pc = pc + 64'd4;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [core_pkg::XLEN-1:0] pc,
    input  logic [11:0]               csr_addr,
    input  core_pkg::csr_op_e         csr_op,
    input  logic [core_pkg::XLEN-1:0] csr_src,
    input  logic                      is_ecall,
    input  logic                      is_mret,
    input  logic                      illegal,
    output logic [core_pkg::XLEN-1:0] csr_rdata,
    output logic                      csr_err,
    output logic                      trap_taken,
    output logic [core_pkg::XLEN-1:0] trap_pc
);
    import core_pkg::*;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] csr_wdata;
    logic            csr_wen;

    always_comb begin
        csr_err = 1'b0;
        case (csr_addr)
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default: begin
                csr_rdata = '0;
                csr_err   = 1'b1;
            end
        endcase
    end

    // read-modify-write value
    always_comb begin
        case (csr_op)
            CSR_WRITE: csr_wdata = csr_src;
            CSR_SET:   csr_wdata = csr_rdata | csr_src;
            CSR_CLEAR: csr_wdata = csr_rdata & ~csr_src;
            default:   csr_wdata = csr_rdata;
        endcase
    end

    assign csr_wen    = (csr_op != CSR_NONE) && !illegal && !csr_err;
    assign trap_taken = (is_ecall || is_mret) && !illegal;
    assign trap_pc    = is_mret ? mepc : {mtvec[XLEN-1:2], 2'b00};

    always_ff @(posedge clk) begin
        if (!rst) begin
            mstatus <= '0;
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end else if (is_ecall && !illegal) begin
            mepc   <= pc;
            mcause <= CAUSE_ECALL_M;
        end else if (csr_wen) begin
            case (csr_addr)
                CSR_MSTATUS: mstatus <= csr_wdata;
                CSR_MTVEC:   mtvec   <= csr_wdata;
                CSR_MEPC:    mepc    <= csr_wdata;
                default:     mcause  <= csr_wdata;
            endcase
        end
    end

    a_trap_onehot: assert property (
        @(posedge clk) disable iff (!rst) !(is_ecall && is_mret)
    );

endmodule

`default_nettype wire

// ==== design/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               instr,
    input  logic [core_pkg::XLEN-1:0] data_rd,
    output logic [core_pkg::XLEN-1:0] pc,
    output logic [core_pkg::XLEN-1:0] addr,
    output logic [core_pkg::XLEN-1:0] data_wr,
    output core_pkg::mem_op_e         mem_op,
    output logic                      mem_rd,
    output logic                      mem_wr,
    output logic                      error,
    output logic                      done
);
    import core_pkg::*;

    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    alu_a_e          alu_a;
    alu_b_e          alu_b;
    branch_e         branch;
    wb_sel_e         wb_sel;
    csr_op_e         csr_op;
    logic            dec_mem_rd;
    logic            dec_mem_wr;
    logic            reg_wen;
    logic            csr_use_imm;
    logic [11:0]     csr_addr;
    logic            is_ecall;
    logic            is_mret;
    logic            is_ebreak;
    logic            illegal;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] csr_src;
    logic [XLEN-1:0] csr_rdata;
    logic            csr_err;
    logic            trap_taken;
    logic [XLEN-1:0] trap_pc;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic            instr_bad;

    fetch_unit u_fetch (
        .clk(clk), .rst(rst), .next_pc(next_pc), .trap_taken(trap_taken),
        .trap_pc(trap_pc), .halt(is_ebreak), .pc(pc)
    );

    instr_decode u_decode (
        .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .branch(branch), .mem_op(mem_op),
        .mem_rd(dec_mem_rd), .mem_wr(dec_mem_wr), .reg_wen(reg_wen), .wb_sel(wb_sel),
        .csr_op(csr_op), .csr_use_imm(csr_use_imm), .csr_addr(csr_addr),
        .is_ecall(is_ecall), .is_mret(is_mret), .is_ebreak(is_ebreak), .illegal(illegal)
    );

    reg_file u_regs (
        .clk(clk), .wen(reg_wen && !instr_bad), .waddr(rd), .wdata(wb_data),
        .raddr1(rs1), .raddr2(rs2), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    exec_unit u_exec (
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b), .branch(branch),
        .alu_result(alu_result), .next_pc(next_pc)
    );

    // zimm form takes the rs1 field itself
    assign csr_src = csr_use_imm ? {{(XLEN-5){1'b0}}, rs1} : rs1_data;

    csr_unit u_csr (
        .clk(clk), .rst(rst), .pc(pc), .csr_addr(csr_addr), .csr_op(csr_op),
        .csr_src(csr_src), .is_ecall(is_ecall), .is_mret(is_mret), .illegal(illegal),
        .csr_rdata(csr_rdata), .csr_err(csr_err), .trap_taken(trap_taken), .trap_pc(trap_pc)
    );

    // ********************************************************
    // load extension and write-back
    // ********************************************************
    always_comb begin
        case (mem_op)
            MEM_B:   load_data = {{56{data_rd[7]}}, data_rd[7:0]};
            MEM_H:   load_data = {{48{data_rd[15]}}, data_rd[15:0]};
            MEM_W:   load_data = {{32{data_rd[31]}}, data_rd[31:0]};
            MEM_BU:  load_data = {56'b0, data_rd[7:0]};
            MEM_HU:  load_data = {48'b0, data_rd[15:0]};
            MEM_WU:  load_data = {32'b0, data_rd[31:0]};
            default: load_data = data_rd;
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_LOAD: wb_data = load_data;
            WB_CSR:  wb_data = csr_rdata;
            default: wb_data = alu_result;
        endcase
    end

    // bad csr address only counts on a csr instruction
    assign instr_bad = illegal || (csr_err && (wb_sel == WB_CSR));

    assign addr    = alu_result;
    assign data_wr = rs2_data;
    assign mem_rd  = dec_mem_rd && !instr_bad && rst;
    assign mem_wr  = dec_mem_wr && !instr_bad && rst;
    assign error   = instr_bad && rst;
    assign done    = is_ebreak && rst;

endmodule

`default_nettype wire

// ==== dv/core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int IMEM_WORDS = 80;
    localparam int DATA_IDX   = 'h50;
    localparam int HDR_IDX    = 'h58;
    localparam int REC_IDX    = 'h60;
    localparam int DMEM_WORDS = 64;
    localparam logic [63:0] DMEM_BASE = 64'h1000;
    localparam int TIMEOUT    = 2000;

    logic            clk;
    logic            rst;
    logic [31:0]     instr;
    logic [XLEN-1:0] data_rd;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] data_wr;
    mem_op_e         mem_op;
    logic            mem_rd;
    logic            mem_wr;
    logic            error;
    logic            done;

    logic [63:0] stim [0:255];
    logic [63:0] dmem [0:DMEM_WORDS-1];
    logic [63:0] exp_pc;
    int          n_rec;
    int          rec_idx;
    int          exp_errors;
    int          err_cycles;
    int          store_fails;
    int          state_fails;
    int          cycles;
    logic        halted;

    core_top u_dut (
        .clk(clk), .rst(rst), .instr(instr), .data_rd(data_rd), .pc(pc),
        .addr(addr), .data_wr(data_wr), .mem_op(mem_op), .mem_rd(mem_rd),
        .mem_wr(mem_wr), .error(error), .done(done)
    );

    always #10 clk = ~clk;

    // ************************************************************
    // memory models
    // ************************************************************
    function automatic logic [31:0] fetch_word(input logic [63:0] a);
        logic [63:0] off;
        off = a - RESET_PC;
        if (off < 64'(IMEM_WORDS * 4)) begin
            fetch_word = stim[off[8:2]][31:0];
        end else begin
            fetch_word = 32'h0;
        end
    endfunction

    function automatic logic in_dmem(input logic [63:0] a);
        in_dmem = (a >= DMEM_BASE) && (a < DMEM_BASE + 64'(DMEM_WORDS * 8));
    endfunction

    // addressed bytes land in the low lanes
    function automatic logic [63:0] load_word(input logic [63:0] a);
        if (in_dmem(a)) begin
            load_word = dmem[a[8:3]] >> {a[2:0], 3'b000};
        end else begin
            load_word = 64'h0;
        end
    endfunction

    function automatic logic [63:0] size_mask(input int nbytes);
        if (nbytes >= 8) begin
            size_mask = '1;
        end else begin
            size_mask = (64'd1 << (8 * nbytes)) - 64'd1;
        end
    endfunction

    // load opcode with one of the seven defined sizes
    function automatic logic is_load_word(input logic [31:0] w);
        is_load_word = (w[6:0] == 7'b0000011) && (w[14:12] != 3'b111);
    endfunction

    task automatic write_bytes(input logic [63:0] a, input logic [63:0] d, input int nbytes);
        logic [2:0] lane;
        for (int b = 0; b < nbytes; b++) begin
            lane = a[2:0] + 3'(b);
            dmem[a[8:3]][lane*8 +: 8] = d[b*8 +: 8];
        end
    endtask

    // ************************************************************
    // checks
    // ************************************************************
    task automatic check_store();
        int          nbytes;
        int          es;
        logic [63:0] ea;
        logic [63:0] ed;
        nbytes = 1 << mem_op[1:0];
        assert (rec_idx < n_rec) else begin
            $display("unexpected extra store to %h at %0t, only %0d stores expected",
                     addr, $time, n_rec);
            store_fails++;
        end
        if (rec_idx < n_rec) begin
            ea = stim[REC_IDX + 3 * rec_idx];
            ed = stim[REC_IDX + 3 * rec_idx + 1] & size_mask(nbytes);
            es = int'(stim[REC_IDX + 3 * rec_idx + 2]);
            assert ((addr == ea) && (nbytes == es) && ((data_wr & size_mask(nbytes)) == ed))
            else begin
                $display("Fail at %0t: store %0d %h/%0d at %h, expected %h/%0d at %h",
                         $time, rec_idx, data_wr & size_mask(nbytes), nbytes, addr,
                         ed, es, ea);
                store_fails++;
            end
            rec_idx++;
        end
        if (in_dmem(addr)) begin
            write_bytes(addr, data_wr, nbytes);
        end
    endtask

    task automatic check_read_strobe();
        assert (mem_rd == is_load_word(instr)) else begin
            $display("Fail at %0t: mem_rd is %b for instruction %h", $time, mem_rd, instr);
            state_fails++;
        end
    endtask

    task automatic check_end();
        assert (pc == exp_pc) else begin
            $display("Fail at %0t: done with pc %h, expected %h", $time, pc, exp_pc);
            state_fails++;
        end
        assert (rec_idx == n_rec) else begin
            $display("done rose after only %0d of %0d expected stores", rec_idx, n_rec);
            state_fails++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b0;
        instr       = 32'h0000_0013;
        data_rd     = '0;
        rec_idx     = 0;
        err_cycles  = 0;
        store_fails = 0;
        state_fails = 0;
        cycles      = 0;
        halted      = 1'b0;

        $readmemh("dv/core_stim.txt", stim);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = (DMEM_BASE + 64'(i * 8)) * 64'h9E37_79B9_7F4A_7C15;
        end
        dmem[0]    = stim[DATA_IDX];
        dmem[1]    = stim[DATA_IDX + 1];
        n_rec      = int'(stim[HDR_IDX]);
        exp_pc     = stim[HDR_IDX + 1];
        exp_errors = int'(stim[HDR_IDX + 2]);

        repeat (4) @(posedge clk);

        // one instruction per cycle, outputs sampled late in the low phase
        while (!halted && (cycles < TIMEOUT)) begin
            @(negedge clk);
            rst   = 1'b1;
            instr = fetch_word(pc);
            #2;
            data_rd = load_word(addr);
            #6;
            check_read_strobe();
            if (mem_wr) begin
                check_store();
            end
            if (error) begin
                err_cycles++;
            end
            if (done) begin
                halted = 1'b1;
                check_end();
            end
            cycles++;
        end

        if (!halted) begin
            $display("timeout, done did not rise within %0d cycles", TIMEOUT);
            state_fails++;
        end
        assert (err_cycles == exp_errors) else begin
            $display("Fail at %0t: saw %0d error cycles, expected %0d",
                     $time, err_cycles, exp_errors);
            state_fails++;
        end

        $display("store errors %0d, end-state errors %0d, error cycles %0d, stores %0d of %0d",
                 store_fails, state_fails, err_cycles, rec_idx, n_rec);
        if ((store_fails + state_fails) == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/core_pkg.sv
design/fetch_unit.sv
design/instr_decode.sv
design/reg_file.sv
design/exec_unit.sv
design/csr_unit.sv
design/core_top.sv
dv/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module core_tb \
    --Mdir obj_dir -o core_sim

output=$(./obj_dir/core_sim)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1

// ==== dv/core_stim.txt ====
// 64-bit words. @00 instruction words at RESET_PC, @50 data words at 0x1000,
// @58 store count / ebreak pc / error cycles, @60 store records: address data bytes
@00
000010B7 FFB00113 00300193 00310233 403102B3 4012D313 02819393 03C15413
003124B3 00313533 0F014593 0032E633 003176B3 1040B023 1050B423 1060B823
1070BC23 1280B023 1290B423 12A0B823 12B0BC23 14C0B023 14D0B423 00008703
0010C783 00209803 0000D883 0040A903 0000E983 0080BA03 14E0B823 14F0BC23
1700B023 1710B423 1720B823 1730BC23 1940B023 1940A423 19409623 19408723
00314463 1E00BC23 00316463 1830B823 00310463 1890BC23 00311463 1E00BC23
0021D463 1E00BC23 0021F463 00800B6F 1E00BC23 00000B97 010B8B93 000B8C67
1E00BC23 1B60B023 1B80B423 00700F93 00000C97 01CC8C93 305C9073 00000073
FFFFFFFF 1DF0B023 00100073 34202D73 34102DF3 1BA0B823 1BB0BC23 004D8D93
341D9073 30200073
@50
F0E1D2C3B4A59687 0123456789ABCDEF
@58
000000000000001B 0000000080000108 0000000000000001
@60
// alu results
1100 FFFFFFFFFFFFFFFE 8
1108 FFFFFFFFFFFFFFF8 8
1110 FFFFFFFFFFFFFFFC 8
1118 0000030000000000 8
1120 000000000000000F 8
1128 0000000000000001 8
1130 0000000000000000 8
1138 FFFFFFFFFFFFFF0B 8
1140 FFFFFFFFFFFFFFFB 8
1148 0000000000000003 8
// loads stored back, then narrow stores
1150 FFFFFFFFFFFFFF87 8
1158 0000000000000096 8
1160 FFFFFFFFFFFFB4A5 8
1168 0000000000009687 8
1170 FFFFFFFFF0E1D2C3 8
1178 00000000B4A59687 8
1180 0123456789ABCDEF 8
1188 0000000089ABCDEF 4
118C 000000000000CDEF 2
118E 00000000000000EF 1
// branch markers and jump links
1190 0000000000000003 8
1198 0000000000000001 8
11A0 00000000800000D0 8
11A8 00000000800000E0 8
// trap handler, then x31 after the illegal word
11B0 000000000000000B 8
11B8 00000000800000FC 8
11C0 0000000000000007 8
